// File: include/npu_cfg.svh
`ifndef NPU_CFG_SVH
`define NPU_CFG_SVH

// Datapath geometry
`define NPU_LANES       8
`define NPU_LANE_W      8     // Signed activation lane
`define NPU_BIAS_W      16    // Signed bias lane
`define NPU_INST_W      64

// Address widths
`define NPU_IOB_AW      8     // 256 words per bank
`define NPU_INST_AW     6     // 64 instructions
`define NPU_BIAS_AW     4     // 16 bias words
`define NPU_DMA_AW      16

// Instruction fields, MSB first
`define NPU_F_OP        63:60
`define NPU_F_DMA_MODE  59:56
`define NPU_F_DMA_SRC   55:40
`define NPU_F_DMA_DST   39:24
`define NPU_F_DMA_LINES 23:16
`define NPU_F_CALC_FLAG 59
`define NPU_F_CALC_ACT  58
`define NPU_F_CALC_SHFT 57:55
`define NPU_F_CALC_SRC  54:47
`define NPU_F_CALC_DST  46:39
`define NPU_F_CALC_BIAS 38:35
`define NPU_F_CALC_LEN  34:27

`endif

// File: hdl/npu_pkg.sv
`include "npu_cfg.svh"

package npu_pkg;

    // Storage words
    typedef logic [`NPU_INST_W-1:0]             inst_t;
    typedef logic [`NPU_LANES*`NPU_LANE_W-1:0]  iob_word_t;
    typedef logic [`NPU_LANES*`NPU_BIAS_W-1:0]  bias_word_t;

    // Addresses
    typedef logic [`NPU_IOB_AW-1:0]  iob_addr_t;
    typedef logic [`NPU_INST_AW-1:0] inst_addr_t;
    typedef logic [`NPU_BIAS_AW-1:0] bias_addr_t;
    typedef logic [`NPU_DMA_AW-1:0]  dma_addr_t;

    // Instruction fields
    typedef logic [3:0] dma_mode_t;
    typedef logic [2:0] shift_t;
    typedef logic [7:0] calc_len_t;   // Word count

    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_DMA  = 4'd1,
        OP_CALC = 4'd2,
        OP_END  = 4'd15
    } opcode_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_DECODE,
        ST_DMA_WAIT,
        ST_CALC_WAIT
    } ctrl_state_e;

    typedef enum logic [1:0] {
        ES_IDLE,
        ES_BIAS,
        ES_RUN,
        ES_DRAIN
    } eng_state_e;

endpackage

// File: hdl/inst_buffer.sv
`timescale 1ns/1ps
`include "npu_cfg.svh"

module inst_buffer (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_host_en,
    input  logic                i_host_we,
    input  npu_pkg::inst_addr_t i_host_addr,
    input  npu_pkg::inst_t      i_host_wdata,
    output npu_pkg::inst_t      o_host_rdata,
    input  logic                i_rd_en,
    input  npu_pkg::inst_addr_t i_raddr,
    output npu_pkg::inst_t      o_inst,
    output logic                o_inst_vld
);
    import npu_pkg::*;

    inst_t mem [0:(1<<`NPU_INST_AW)-1];

    always_ff @(posedge i_clk) begin
        if (i_host_en) begin
            if (i_host_we) mem[i_host_addr] <= i_host_wdata;
            else           o_host_rdata     <= mem[i_host_addr];
        end
        if (i_rd_en) o_inst <= mem[i_raddr];   // Fetch port
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_inst_vld <= 1'b0;
        end else begin
            o_inst_vld <= i_rd_en;
        end
    end

endmodule

// File: hdl/io_buffer.sv
`timescale 1ns/1ps
`include "npu_cfg.svh"

module io_buffer (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_host_en,
    input  logic               i_host_we,
    input  npu_pkg::iob_addr_t i_host_addr,
    input  npu_pkg::iob_word_t i_host_wdata,
    output npu_pkg::iob_word_t o_host_rdata,
    input  logic               i_rwsel,     // High when this bank is the source
    input  logic               i_rd_en,
    input  npu_pkg::iob_addr_t i_raddr,
    input  logic               i_wr_en,
    input  npu_pkg::iob_addr_t i_waddr,
    input  npu_pkg::iob_word_t i_wdata,
    output npu_pkg::iob_word_t o_rdata
);
    import npu_pkg::*;

    iob_word_t mem [0:(1<<`NPU_IOB_AW)-1];
    logic      eng_rd;
    logic      eng_wr;

    // Host wins whenever it is enabled
    assign eng_rd = i_rd_en && i_rwsel && !i_host_en;
    assign eng_wr = i_wr_en && !i_rwsel && !i_host_en;

    always_ff @(posedge i_clk) begin
        if (i_host_en) begin
            if (i_host_we) mem[i_host_addr] <= i_host_wdata;
            else           o_host_rdata     <= mem[i_host_addr];
        end else if (eng_wr) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // Zero when not the source so the top can OR both banks
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rdata <= '0;
        end else begin
            o_rdata <= eng_rd ? mem[i_raddr] : '0;
        end
    end

endmodule

// File: hdl/bias_buffer.sv
`timescale 1ns/1ps
`include "npu_cfg.svh"

module bias_buffer (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_host_en,
    input  logic                i_host_we,
    input  npu_pkg::bias_addr_t i_host_addr,
    input  npu_pkg::bias_word_t i_host_wdata,
    output npu_pkg::bias_word_t o_host_rdata,
    input  logic                i_rd_en,
    input  npu_pkg::bias_addr_t i_raddr,
    output npu_pkg::bias_word_t o_rdata
);
    import npu_pkg::*;

    bias_word_t mem [0:(1<<`NPU_BIAS_AW)-1];

    always_ff @(posedge i_clk) begin
        if (i_host_en) begin
            if (i_host_we) mem[i_host_addr] <= i_host_wdata;
            else           o_host_rdata     <= mem[i_host_addr];
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rdata <= '0;
        end else if (i_rd_en) begin
            o_rdata <= mem[i_raddr];   // Held until next engine read
        end
    end

endmodule

// File: hdl/inst_ctrl.sv
`timescale 1ns/1ps
`include "npu_cfg.svh"

module inst_ctrl (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_start_npu,
    input  logic                i_stop_npu,
    // Fetch
    output logic                o_inst_rd_en,
    output npu_pkg::inst_addr_t o_pc,
    input  npu_pkg::inst_t      i_inst,
    input  logic                i_inst_vld,
    // DMA
    output logic                o_ex_dma,
    output npu_pkg::dma_mode_t  o_dma_mode,
    output npu_pkg::dma_addr_t  o_src_start,
    output npu_pkg::dma_addr_t  o_dest_start,
    output npu_pkg::calc_len_t  o_d_lines,
    input  logic                i_dma_finish,
    // Status
    output logic                o_npu_idle,
    output logic                o_internal_stop,
    // Engine
    output logic                o_calc_start,
    output logic                o_buffer_flag,
    output logic                o_act_relu,
    output npu_pkg::shift_t     o_shift,
    output npu_pkg::iob_addr_t  o_src_addr,
    output npu_pkg::iob_addr_t  o_dst_addr,
    output npu_pkg::bias_addr_t o_bias_addr,
    output npu_pkg::calc_len_t  o_calc_len,
    input  logic                i_calc_done
);
    import npu_pkg::*;

    ctrl_state_e state;
    inst_addr_t  pc;
    logic        stop_q;
    opcode_e     opcode;
    logic        dec_vld;

    assign opcode       = opcode_e'(i_inst[`NPU_F_OP]);
    assign dec_vld      = (state == ST_DECODE) && i_inst_vld;
    assign o_pc         = pc;
    assign o_inst_rd_en = (state == ST_FETCH) && !stop_q;

    // Stop request waits for the next fetch boundary
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            stop_q <= 1'b0;
        end else if (state == ST_IDLE) begin
            stop_q <= 1'b0;
        end else if (i_stop_npu) begin
            stop_q <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state           <= ST_IDLE;
            pc              <= '0;
            o_npu_idle      <= 1'b1;
            o_internal_stop <= 1'b0;
            o_ex_dma        <= 1'b0;
            o_calc_start    <= 1'b0;
        end else begin
            o_internal_stop <= 1'b0;
            o_ex_dma        <= 1'b0;
            o_calc_start    <= 1'b0;
            case (state)
                ST_IDLE: if (i_start_npu) begin
                    pc         <= '0;
                    o_npu_idle <= 1'b0;
                    state      <= ST_FETCH;
                end
                ST_FETCH: if (stop_q) begin
                    o_npu_idle      <= 1'b1;
                    o_internal_stop <= 1'b1;
                    state           <= ST_IDLE;
                end else begin
                    state <= ST_DECODE;   // Word valid next cycle
                end
                ST_DECODE: if (i_inst_vld) begin
                    case (opcode)
                        OP_DMA: begin
                            o_ex_dma <= 1'b1;
                            state    <= ST_DMA_WAIT;
                        end
                        OP_CALC: begin
                            o_calc_start <= 1'b1;
                            state        <= ST_CALC_WAIT;
                        end
                        OP_END: begin
                            o_npu_idle      <= 1'b1;
                            o_internal_stop <= 1'b1;
                            state           <= ST_IDLE;
                        end
                        default: begin   // NOP and unknown codes skip
                            pc    <= pc + 1'b1;
                            state <= ST_FETCH;
                        end
                    endcase
                end
                ST_DMA_WAIT: if (i_dma_finish) begin
                    pc    <= pc + 1'b1;
                    state <= ST_FETCH;
                end
                ST_CALC_WAIT: if (i_calc_done) begin
                    pc    <= pc + 1'b1;
                    state <= ST_FETCH;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Decoded fields, held until the next instruction of the same kind
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_dma_mode    <= '0;
            o_src_start   <= '0;
            o_dest_start  <= '0;
            o_d_lines     <= '0;
            o_buffer_flag <= 1'b0;
            o_act_relu    <= 1'b0;
            o_shift       <= '0;
            o_src_addr    <= '0;
            o_dst_addr    <= '0;
            o_bias_addr   <= '0;
            o_calc_len    <= '0;
        end else if (dec_vld && opcode == OP_DMA) begin
            o_dma_mode   <= i_inst[`NPU_F_DMA_MODE];
            o_src_start  <= i_inst[`NPU_F_DMA_SRC];
            o_dest_start <= i_inst[`NPU_F_DMA_DST];
            o_d_lines    <= i_inst[`NPU_F_DMA_LINES];
        end else if (dec_vld && opcode == OP_CALC) begin
            o_buffer_flag <= i_inst[`NPU_F_CALC_FLAG];
            o_act_relu    <= i_inst[`NPU_F_CALC_ACT];
            o_shift       <= i_inst[`NPU_F_CALC_SHFT];
            o_src_addr    <= i_inst[`NPU_F_CALC_SRC];
            o_dst_addr    <= i_inst[`NPU_F_CALC_DST];
            o_bias_addr   <= i_inst[`NPU_F_CALC_BIAS];
            o_calc_len    <= i_inst[`NPU_F_CALC_LEN];
        end
    end

endmodule

// File: hdl/vector_engine.sv
`timescale 1ns/1ps
`include "npu_cfg.svh"

module vector_engine (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_calc_start,
    input  logic                i_act_relu,
    input  npu_pkg::shift_t     i_shift,
    input  npu_pkg::iob_addr_t  i_src_addr,
    input  npu_pkg::iob_addr_t  i_dst_addr,
    input  npu_pkg::bias_addr_t i_bias_addr,
    input  npu_pkg::calc_len_t  i_calc_len,
    output logic                o_calc_done,
    output logic                o_bias_rd_en,
    output npu_pkg::bias_addr_t o_bias_addr,
    input  npu_pkg::bias_word_t i_bias,
    output logic                o_rd_en,
    output npu_pkg::iob_addr_t  o_raddr,
    input  npu_pkg::iob_word_t  i_rdata,
    output logic                o_wr_en,
    output npu_pkg::iob_addr_t  o_waddr,
    output npu_pkg::iob_word_t  o_wdata
);
    import npu_pkg::*;

    eng_state_e state;
    calc_len_t  idx;        // Read word index
    calc_len_t  s1_idx;     // Index of the word now on i_rdata
    logic       s1_vld;
    bias_word_t bias_q;
    iob_word_t  result;

    // Bias add, arithmetic shift, optional ReLU, saturate to int8
    function automatic logic [`NPU_LANE_W-1:0] lane_op(
        input logic signed [`NPU_LANE_W-1:0] act,
        input logic signed [`NPU_BIAS_W-1:0] bias,
        input shift_t                        sh,
        input logic                          relu
    );
        logic signed [`NPU_BIAS_W:0] sum;
        sum = act + bias;
        sum = sum >>> sh;
        if (relu && sum < 0) sum = '0;
        if (sum > 17'sd127)  return 8'h7f;
        if (sum < -17'sd128) return 8'h80;
        return sum[`NPU_LANE_W-1:0];
    endfunction

    always_comb begin
        for (int l = 0; l < `NPU_LANES; l++) begin
            result[l*`NPU_LANE_W +: `NPU_LANE_W] =
                lane_op(i_rdata[l*`NPU_LANE_W +: `NPU_LANE_W],
                        bias_q[l*`NPU_BIAS_W +: `NPU_BIAS_W], i_shift, i_act_relu);
        end
    end

    assign o_bias_rd_en = (state == ES_BIAS);
    assign o_bias_addr  = i_bias_addr;
    assign o_rd_en      = (state == ES_RUN);
    assign o_raddr      = i_src_addr + idx;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state       <= ES_IDLE;
            idx         <= '0;
            s1_vld      <= 1'b0;
            o_wr_en     <= 1'b0;
            o_calc_done <= 1'b0;
        end else begin
            o_calc_done <= 1'b0;
            s1_vld      <= o_rd_en;
            o_wr_en     <= s1_vld;    // Write two cycles after the read
            case (state)
                ES_IDLE: if (i_calc_start) begin
                    idx   <= '0;
                    state <= ES_BIAS;
                end
                ES_BIAS: state <= ES_RUN;
                ES_RUN: begin
                    idx <= idx + 1'b1;
                    if (idx == i_calc_len - 1'b1) state <= ES_DRAIN;
                end
                ES_DRAIN: if (o_wr_en && !s1_vld) begin   // Last write this cycle
                    o_calc_done <= 1'b1;
                    state       <= ES_IDLE;
                end
                default: state <= ES_IDLE;
            endcase
        end
    end

    // Datapath registers
    always_ff @(posedge i_clk) begin
        if (state == ES_RUN && idx == '0) bias_q <= i_bias;   // Bias data lands here
        s1_idx  <= idx;
        o_waddr <= i_dst_addr + s1_idx;
        o_wdata <= result;
    end

endmodule

// File: hdl/npu_core.sv
`timescale 1ns/1ps

module npu_core (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_start_npu,
    input  logic                i_stop_npu,
    // DMA
    output npu_pkg::dma_addr_t  o_src_start,
    output npu_pkg::dma_addr_t  o_dest_start,
    output npu_pkg::calc_len_t  o_d_lines,
    output npu_pkg::dma_mode_t  o_dma_mode,
    output logic                o_ex_dma,
    input  logic                i_dma_finish,
    output logic                o_npu_idle,
    output logic                o_internal_stop,
    // Host ports
    input  logic                i_inst_bramctl_en,
    input  logic                i_inst_bramctl_we,
    input  npu_pkg::inst_addr_t i_inst_bramctl_addr,
    input  npu_pkg::inst_t      i_inst_bramctl_wdata,
    output npu_pkg::inst_t      o_inst_bramctl_rdata,
    input  logic                i_iob_0_bramctl_en,
    input  logic                i_iob_0_bramctl_we,
    input  npu_pkg::iob_addr_t  i_iob_0_bramctl_addr,
    input  npu_pkg::iob_word_t  i_iob_0_bramctl_wdata,
    output npu_pkg::iob_word_t  o_iob_0_bramctl_rdata,
    input  logic                i_iob_1_bramctl_en,
    input  logic                i_iob_1_bramctl_we,
    input  npu_pkg::iob_addr_t  i_iob_1_bramctl_addr,
    input  npu_pkg::iob_word_t  i_iob_1_bramctl_wdata,
    output npu_pkg::iob_word_t  o_iob_1_bramctl_rdata,
    input  logic                i_bias_bramctl_en,
    input  logic                i_bias_bramctl_we,
    input  npu_pkg::bias_addr_t i_bias_bramctl_addr,
    input  npu_pkg::bias_word_t i_bias_bramctl_wdata,
    output npu_pkg::bias_word_t o_bias_bramctl_rdata
);
    import npu_pkg::*;

    logic       c_inst_rd_en, c_inst_vld;
    inst_addr_t c_pc;
    inst_t      c_inst;
    logic       c_calc_start, c_calc_done, c_buffer_flag, c_act_relu;
    shift_t     c_shift;
    iob_addr_t  c_src_addr, c_dst_addr, c_raddr, c_waddr;
    bias_addr_t c_bias_addr, c_bias_raddr;
    calc_len_t  c_calc_len;
    logic       c_bias_rd_en, c_rd_en, c_wr_en;
    bias_word_t c_bias;
    iob_word_t  c_rdata_0, c_rdata_1, c_wdata;

    ////////////////////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////////////////////
    inst_ctrl u_inst_ctrl (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_start_npu(i_start_npu), .i_stop_npu(i_stop_npu),
        .o_inst_rd_en(c_inst_rd_en), .o_pc(c_pc),
        .i_inst(c_inst), .i_inst_vld(c_inst_vld),
        .o_ex_dma(o_ex_dma), .o_dma_mode(o_dma_mode),
        .o_src_start(o_src_start), .o_dest_start(o_dest_start),
        .o_d_lines(o_d_lines), .i_dma_finish(i_dma_finish),
        .o_npu_idle(o_npu_idle), .o_internal_stop(o_internal_stop),
        .o_calc_start(c_calc_start), .o_buffer_flag(c_buffer_flag),
        .o_act_relu(c_act_relu), .o_shift(c_shift),
        .o_src_addr(c_src_addr), .o_dst_addr(c_dst_addr),
        .o_bias_addr(c_bias_addr), .o_calc_len(c_calc_len),
        .i_calc_done(c_calc_done)
    );

    inst_buffer u_inst_buffer (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_host_en(i_inst_bramctl_en), .i_host_we(i_inst_bramctl_we),
        .i_host_addr(i_inst_bramctl_addr), .i_host_wdata(i_inst_bramctl_wdata),
        .o_host_rdata(o_inst_bramctl_rdata),
        .i_rd_en(c_inst_rd_en), .i_raddr(c_pc),
        .o_inst(c_inst), .o_inst_vld(c_inst_vld)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Ping-pong banks, flag 0 reads bank 0
    ////////////////////////////////////////////////////////////////////////////
    io_buffer u_iob_0 (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_host_en(i_iob_0_bramctl_en), .i_host_we(i_iob_0_bramctl_we),
        .i_host_addr(i_iob_0_bramctl_addr), .i_host_wdata(i_iob_0_bramctl_wdata),
        .o_host_rdata(o_iob_0_bramctl_rdata),
        .i_rwsel(~c_buffer_flag),
        .i_rd_en(c_rd_en), .i_raddr(c_raddr),
        .i_wr_en(c_wr_en), .i_waddr(c_waddr), .i_wdata(c_wdata),
        .o_rdata(c_rdata_0)
    );

    io_buffer u_iob_1 (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_host_en(i_iob_1_bramctl_en), .i_host_we(i_iob_1_bramctl_we),
        .i_host_addr(i_iob_1_bramctl_addr), .i_host_wdata(i_iob_1_bramctl_wdata),
        .o_host_rdata(o_iob_1_bramctl_rdata),
        .i_rwsel(c_buffer_flag),
        .i_rd_en(c_rd_en), .i_raddr(c_raddr),
        .i_wr_en(c_wr_en), .i_waddr(c_waddr), .i_wdata(c_wdata),
        .o_rdata(c_rdata_1)
    );

    bias_buffer u_bias_buffer (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_host_en(i_bias_bramctl_en), .i_host_we(i_bias_bramctl_we),
        .i_host_addr(i_bias_bramctl_addr), .i_host_wdata(i_bias_bramctl_wdata),
        .o_host_rdata(o_bias_bramctl_rdata),
        .i_rd_en(c_bias_rd_en), .i_raddr(c_bias_raddr), .o_rdata(c_bias)
    );

    vector_engine u_vector_engine (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_calc_start(c_calc_start), .i_act_relu(c_act_relu), .i_shift(c_shift),
        .i_src_addr(c_src_addr), .i_dst_addr(c_dst_addr),
        .i_bias_addr(c_bias_addr), .i_calc_len(c_calc_len),
        .o_calc_done(c_calc_done),
        .o_bias_rd_en(c_bias_rd_en), .o_bias_addr(c_bias_raddr), .i_bias(c_bias),
        .o_rd_en(c_rd_en), .o_raddr(c_raddr),
        .i_rdata(c_rdata_0 | c_rdata_1),   // Idle bank drives zero
        .o_wr_en(c_wr_en), .o_waddr(c_waddr), .o_wdata(c_wdata)
    );

endmodule

// File: bench/tb_npu_core.sv
`timescale 1ns/1ps

module tb_npu_core;

    localparam int CLK_PERIOD = 20;
    localparam int PROG_LEN   = 4;
    localparam int CALC_LEN   = 3;
    localparam int NOP_COUNT  = 32;
    localparam int DMA_MAX    = 8;
    // Cycle budgets from instruction count, DMA delay and CALC length
    localparam int RUN_LIMIT  = 4 * PROG_LEN + 2 * DMA_MAX + 2 * (2 * CALC_LEN + 8);
    localparam int STOP_LIMIT = 2 * NOP_COUNT + 8;
    localparam int HOST_OPS   = 5 * PROG_LEN + 6 * CALC_LEN + NOP_COUNT + 8;
    localparam int WATCHDOG_CYCLES = 3 * HOST_OPS + RUN_LIMIT + STOP_LIMIT + 100;

    // Host memory select
    localparam int M_INST = 0;
    localparam int M_IOB0 = 1;
    localparam int M_IOB1 = 2;
    localparam int M_BIAS = 3;

    logic         i_clk;
    logic         i_rst_n;
    logic         i_start_npu;
    logic         i_stop_npu;
    logic         i_dma_finish;
    logic [15:0]  o_src_start;
    logic [15:0]  o_dest_start;
    logic [7:0]   o_d_lines;
    logic [3:0]   o_dma_mode;
    logic         o_ex_dma;
    logic         o_npu_idle;
    logic         o_internal_stop;
    logic [3:0]   host_en;        // One enable per memory
    logic         host_we;
    logic [7:0]   host_addr;
    logic [127:0] host_wdata;
    logic [63:0]  inst_rdata;
    logic [63:0]  iob0_rdata;
    logic [63:0]  iob1_rdata;
    logic [127:0] bias_rdata;

    logic [127:0] pat [0:14];     // Program, sources, bias, expected results
    integer       seed = 32'h30ac;
    int           mismatches = 0;
    int           failures = 0;
    int           stop_pulses = 0;
    int           dma_count = 0;

    npu_core i_dut (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_start_npu(i_start_npu), .i_stop_npu(i_stop_npu),
        .o_src_start(o_src_start), .o_dest_start(o_dest_start),
        .o_d_lines(o_d_lines), .o_dma_mode(o_dma_mode),
        .o_ex_dma(o_ex_dma), .i_dma_finish(i_dma_finish),
        .o_npu_idle(o_npu_idle), .o_internal_stop(o_internal_stop),
        .i_inst_bramctl_en(host_en[M_INST]), .i_inst_bramctl_we(host_we),
        .i_inst_bramctl_addr(host_addr[5:0]), .i_inst_bramctl_wdata(host_wdata[63:0]),
        .o_inst_bramctl_rdata(inst_rdata),
        .i_iob_0_bramctl_en(host_en[M_IOB0]), .i_iob_0_bramctl_we(host_we),
        .i_iob_0_bramctl_addr(host_addr), .i_iob_0_bramctl_wdata(host_wdata[63:0]),
        .o_iob_0_bramctl_rdata(iob0_rdata),
        .i_iob_1_bramctl_en(host_en[M_IOB1]), .i_iob_1_bramctl_we(host_we),
        .i_iob_1_bramctl_addr(host_addr), .i_iob_1_bramctl_wdata(host_wdata[63:0]),
        .o_iob_1_bramctl_rdata(iob1_rdata),
        .i_bias_bramctl_en(host_en[M_BIAS]), .i_bias_bramctl_we(host_we),
        .i_bias_bramctl_addr(host_addr[3:0]), .i_bias_bramctl_wdata(host_wdata),
        .o_bias_bramctl_rdata(bias_rdata)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    always @(negedge i_clk) begin
        if (o_internal_stop === 1'b1) stop_pulses++;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_val(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
        if (got !== exp) begin
            $display("mismatch %s exp=%0h got=%0h at %0t", name, exp, got, $time);
            mismatches++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("error: %s at %0t", what, $time);
        failures++;
    endtask

    task automatic host_write(input int sel, input logic [7:0] addr,
                              input logic [127:0] data);
        @(posedge i_clk);
        host_en    <= 4'b0001 << sel;
        host_we    <= 1'b1;
        host_addr  <= addr;
        host_wdata <= data;
        @(posedge i_clk);
        host_en <= '0;
        host_we <= 1'b0;
    endtask

    // Read data lands one cycle after the enable
    task automatic host_read(input int sel, input logic [7:0] addr,
                             output logic [127:0] data);
        @(posedge i_clk);
        host_en   <= 4'b0001 << sel;
        host_we   <= 1'b0;
        host_addr <= addr;
        @(posedge i_clk);
        host_en <= '0;
        @(negedge i_clk);
        case (sel)
            M_INST:  data = {64'b0, inst_rdata};
            M_IOB0:  data = {64'b0, iob0_rdata};
            M_IOB1:  data = {64'b0, iob1_rdata};
            default: data = bias_rdata;
        endcase
    endtask

    task automatic run_program(input int limit, output int cycles);
        int stops_before;
        stops_before = stop_pulses;
        @(posedge i_clk);
        i_start_npu <= 1'b1;
        @(posedge i_clk);
        i_start_npu <= 1'b0;
        @(negedge i_clk);
        if (o_npu_idle !== 1'b0) report_failure("core stayed idle after start");
        cycles = 0;
        while (o_npu_idle !== 1'b1 && cycles < limit) begin
            @(negedge i_clk);
            cycles++;
        end
        if (o_npu_idle !== 1'b1) report_failure("core did not return to idle in time");
        repeat (2) @(negedge i_clk);
        if (stop_pulses - stops_before != 1) begin
            report_failure("o_internal_stop did not pulse exactly once");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // DMA model, finish after 1 to 8 cycles
    ////////////////////////////////////////////////////////////////////////////
    initial begin : dma_model
        int delay;
        i_dma_finish = 1'b0;
        forever begin
            @(negedge i_clk);
            if (o_ex_dma === 1'b1) begin
                dma_count++;
                check_val("o_dma_mode", o_dma_mode, pat[0][59:56]);
                check_val("o_src_start", o_src_start, pat[0][55:40]);
                check_val("o_dest_start", o_dest_start, pat[0][39:24]);
                check_val("o_d_lines", o_d_lines, pat[0][23:16]);
                delay = 1 + {$random(seed)} % DMA_MAX;
                repeat (delay) begin
                    @(negedge i_clk);
                    if (o_ex_dma !== 1'b0) report_failure("second DMA issued before finish");
                    if (o_npu_idle !== 1'b0) report_failure("core went idle with a DMA pending");
                end
                @(posedge i_clk);
                i_dma_finish <= 1'b1;
                @(posedge i_clk);
                i_dma_finish <= 1'b0;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("error: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin : main_seq
        logic [127:0] rd;
        int           cycles;
        i_rst_n     = 1'b0;
        i_start_npu = 1'b0;
        i_stop_npu  = 1'b0;
        host_en     = '0;
        host_we     = 1'b0;
        host_addr   = '0;
        host_wdata  = '0;
        $readmemh("bench/npu_patterns.hex", pat);
        repeat (3) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(negedge i_clk);
        check_val("o_npu_idle", o_npu_idle, 1);
        check_val("o_ex_dma", o_ex_dma, 0);
        check_val("o_internal_stop", o_internal_stop, 0);

        // Load all four memories, then read them back
        for (int i = 0; i < PROG_LEN; i++) host_write(M_INST, 8'(i), pat[i]);
        for (int i = 0; i < CALC_LEN; i++) host_write(M_IOB0, 8'(i), pat[4 + i]);
        host_write(M_BIAS, 8'd1, pat[7]);
        host_write(M_BIAS, 8'd2, pat[8]);
        host_write(M_IOB1, 8'h40, {64'b0, ~pat[4][63:0]});
        for (int i = 0; i < PROG_LEN; i++) begin
            host_read(M_INST, 8'(i), rd);
            check_val($sformatf("o_inst_bramctl_rdata[%0h]", i), rd, pat[i]);
        end
        for (int i = 0; i < 2; i++) begin
            host_read(M_BIAS, 8'(i + 1), rd);
            check_val($sformatf("o_bias_bramctl_rdata[%0h]", i + 1), rd, pat[7 + i]);
        end
        host_read(M_IOB1, 8'h40, rd);
        check_val("o_iob_1_bramctl_rdata[40]", rd, {64'b0, ~pat[4][63:0]});

        // DMA, CALC bank 0 to bank 1, CALC bank 1 to bank 0, END
        run_program(RUN_LIMIT, cycles);
        if (dma_count != 1) report_failure("expected exactly one DMA request");
        for (int i = 0; i < CALC_LEN; i++) begin
            host_read(M_IOB1, 8'(8'h10 + i), rd);
            check_val($sformatf("o_iob_1_bramctl_rdata[%0h]", 8'h10 + i), rd, pat[9 + i]);
            host_read(M_IOB0, 8'(8'h20 + i), rd);
            check_val($sformatf("o_iob_0_bramctl_rdata[%0h]", 8'h20 + i), rd, pat[12 + i]);
            host_read(M_IOB0, 8'(i), rd);
            check_val($sformatf("o_iob_0_bramctl_rdata[%0h]", i), rd, pat[4 + i]);
        end

        // NOP program ending in END, stopped part way
        for (int i = 0; i < NOP_COUNT; i++) host_write(M_INST, 8'(i), '0);
        host_write(M_INST, 8'(NOP_COUNT), pat[3]);
        fork
            run_program(STOP_LIMIT, cycles);
            begin
                repeat (10) @(posedge i_clk);
                i_stop_npu <= 1'b1;
                @(posedge i_clk);
                i_stop_npu <= 1'b0;
            end
        join
        if (cycles >= 2 * NOP_COUNT) report_failure("stop was not honored before END");

        repeat (2) @(negedge i_clk);
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: bench/npu_patterns.hex
// Entries 0-3 program, 4-6 bank 0 words 0x00-0x02, 7-8 bias words 1-2
// Entries 9-11 expected bank 1 words 0x10-0x12, 12-14 expected bank 0 words 0x20-0x22
131234abcd100000
2500080818000000
2808101018000000
f000000000000000
ff20807f00081040
0503300180507fc0
6cfe00907f64f012
0001fffc0020ff000100fff000040000
ff800050ffc0000afff6ff0001000000
0007000040000510
0100140020102000
1b0008005f150004
8057c00a36807f10
8150d40a16807f00
9b50c80a55807f04

// File: tb.f
+incdir+include
hdl/npu_pkg.sv
hdl/inst_buffer.sv
hdl/io_buffer.sv
hdl/bias_buffer.sv
hdl/inst_ctrl.sv
hdl/vector_engine.sv
hdl/npu_core.sv
bench/tb_npu_core.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run for tb_npu_core
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing -Wno-fatal --top-module tb_npu_core \
        -f tb.f -o tb_npu_core; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_npu_core > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error"
    exit 1
fi
cat "$LOG"

# Pass only when the pass line is in the log
if grep -qx "TEST PASS" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1
